//--- hdl/la32_decode_config.svh
`ifndef LA32_DECODE_CONFIG_SVH
`define LA32_DECODE_CONFIG_SVH

// instruction and register index widths
`define LA32_INST_W 32
`define LA32_REG_W 5

// register index fields, lsb of each 5-bit slot
`define LA32_RD_LSB 0
`define LA32_RJ_LSB 5
`define LA32_RK_LSB 10

// lsb of the opcode slices used by the decoders, all of them run up to bit 31
`define LA32_OP6_LSB 26
`define LA32_OP10_LSB 22
`define LA32_OP17_LSB 15

`endif

//--- hdl/la32_isa_pkg.sv
`default_nettype none

package la32_isa_pkg;

    // what feeds operand 0 of the execute stage
    typedef enum logic [2:0] {
        REG_R0_NONE = 3'd0,
        REG_R0_RD   = 3'd1,
        REG_R0_RK   = 3'd2,
        REG_R0_IMM  = 3'd3
    } reg_r0_e;

    typedef enum logic {
        REG_R1_NONE = 1'b0,
        REG_R1_RJ   = 1'b1
    } reg_r1_e;

    typedef enum logic [1:0] {
        REG_W_NONE = 2'd0,
        REG_W_RD   = 2'd1,
        REG_W_R1   = 2'd2  // bl writes the return address to r1
    } reg_w_e;

    // immediate kinds of the ALU forms
    typedef enum logic [2:0] {
        IMM_U5  = 3'd0,
        IMM_S12 = 3'd1,
        IMM_U12 = 3'd2,
        IMM_S20 = 3'd3
    } imm_e;

    // offset kinds of loads, stores and jumps
    typedef enum logic [1:0] {
        ADDR_IMM_S12 = 2'd0,
        ADDR_IMM_S16 = 2'd1,
        ADDR_IMM_S26 = 2'd2
    } addr_imm_e;

endpackage

`default_nettype wire

//--- hdl/la32_uop_pkg.sv
`default_nettype none

`include "la32_decode_config.svh"

package la32_uop_pkg;

    import la32_isa_pkg::*;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_MDU, UNIT_LSU} unit_e;

    typedef enum logic [2:0] {
        ALU_GTYPE_BW, ALU_GTYPE_LI, ALU_GTYPE_INT,
        ALU_GTYPE_SFT, ALU_GTYPE_MUL, ALU_GTYPE_DIV
    } alu_gtype_e;

    // subtype codes overlap between groups, so they are plain constants
    typedef logic [1:0] alu_stype_e;

    localparam alu_stype_e ALU_STYPE_AND     = 2'd0;
    localparam alu_stype_e ALU_STYPE_OR      = 2'd1;
    localparam alu_stype_e ALU_STYPE_XOR     = 2'd2;
    localparam alu_stype_e ALU_STYPE_NOR     = 2'd3;
    localparam alu_stype_e ALU_STYPE_ADD     = 2'd0;
    localparam alu_stype_e ALU_STYPE_SUB     = 2'd1;
    localparam alu_stype_e ALU_STYPE_SLT     = 2'd2;
    localparam alu_stype_e ALU_STYPE_SLTU    = 2'd3;
    localparam alu_stype_e ALU_STYPE_SLL     = 2'd0;
    localparam alu_stype_e ALU_STYPE_SRL     = 2'd1;
    localparam alu_stype_e ALU_STYPE_SRA     = 2'd2;
    localparam alu_stype_e ALU_STYPE_LUI     = 2'd0;
    localparam alu_stype_e ALU_STYPE_PCADDUI = 2'd1;
    localparam alu_stype_e ALU_STYPE_PCPLUS4 = 2'd2;
    localparam alu_stype_e ALU_STYPE_MULL    = 2'd0;
    localparam alu_stype_e ALU_STYPE_MULH    = 2'd1;
    localparam alu_stype_e ALU_STYPE_MULHU   = 2'd2;
    localparam alu_stype_e ALU_STYPE_DIV     = 2'd0;
    localparam alu_stype_e ALU_STYPE_MOD     = 2'd1;
    localparam alu_stype_e ALU_STYPE_DIVU    = 2'd2;
    localparam alu_stype_e ALU_STYPE_MODU    = 2'd3;

    typedef enum logic [2:0] {
        CMP_NONE, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_e;

    typedef enum logic {TARGET_REL, TARGET_ABS} target_e;

    typedef enum logic [2:0] {
        MEM_TYPE_BYTE, MEM_TYPE_HALF, MEM_TYPE_WORD, MEM_TYPE_UBYTE, MEM_TYPE_UHALF
    } mem_type_e;

    typedef struct packed {
        logic [`LA32_INST_W-1:0] inst;
        unit_e                   unit;
        reg_r0_e                 reg_r0;
        reg_r1_e                 reg_r1;
        reg_w_e                  reg_w;
        imm_e                    imm_type;
        addr_imm_e               addr_imm_type;
        alu_gtype_e              alu_gtype;
        alu_stype_e              alu_stype;
        target_e                 target_type;
        cmp_e                    cmp_type;
        logic                    jump;
    } exec_ctrl_t;

    typedef struct packed {
        mem_type_e mem_type;
        logic      mem_read;
        logic      mem_write;
    } mem_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/la32_int_decoder.sv
`default_nettype none
`timescale 1ns/1ns

`include "la32_decode_config.svh"

module la32_int_decoder (
    input  logic [`LA32_INST_W-1:0] inst_i,
    output logic                    hit_o,
    output la32_uop_pkg::exec_ctrl_t exec_o
);

    import la32_isa_pkg::*;
    import la32_uop_pkg::*;

    // per-opcode decode result before it is spread into the bundle
    typedef struct packed {
        logic       hit;
        reg_r0_e    r0;
        reg_r1_e    r1;
        imm_e       imm;
        alu_gtype_e gtype;
        alu_stype_e stype;
    } op_t;

    localparam op_t NO_OP = '{1'b0, REG_R0_NONE, REG_R1_NONE, IMM_U5, ALU_GTYPE_BW, 2'd0};

    logic [`LA32_INST_W-1:`LA32_OP17_LSB] opc17;
    op_t                                  op;

    // register-register form, rk and rj in
    function automatic op_t rr(input alu_gtype_e g, input alu_stype_e s);
        return '{1'b1, REG_R0_RK, REG_R1_RJ, IMM_U5, g, s};
    endfunction

    // register-immediate form, imm and rj in
    function automatic op_t ri(input imm_e k, input alu_gtype_e g, input alu_stype_e s);
        return '{1'b1, REG_R0_IMM, REG_R1_RJ, k, g, s};
    endfunction

    function automatic op_t ri20(input alu_stype_e s);
        return '{1'b1, REG_R0_IMM, REG_R1_NONE, IMM_S20, ALU_GTYPE_LI, s};
    endfunction

    assign opc17 = inst_i[`LA32_INST_W-1:`LA32_OP17_LSB];

    always_comb begin
        unique casez (opc17)
            17'b00000000000100000: op = rr(ALU_GTYPE_INT, ALU_STYPE_ADD);
            17'b00000000000100010: op = rr(ALU_GTYPE_INT, ALU_STYPE_SUB);
            17'b00000000000100100: op = rr(ALU_GTYPE_INT, ALU_STYPE_SLT);
            17'b00000000000100101: op = rr(ALU_GTYPE_INT, ALU_STYPE_SLTU);
            17'b00000000000101000: op = rr(ALU_GTYPE_BW, ALU_STYPE_NOR);
            17'b00000000000101001: op = rr(ALU_GTYPE_BW, ALU_STYPE_AND);
            17'b00000000000101010: op = rr(ALU_GTYPE_BW, ALU_STYPE_OR);
            17'b00000000000101011: op = rr(ALU_GTYPE_BW, ALU_STYPE_XOR);
            17'b00000000000101110: op = rr(ALU_GTYPE_SFT, ALU_STYPE_SLL);
            17'b00000000000101111: op = rr(ALU_GTYPE_SFT, ALU_STYPE_SRL);
            17'b00000000000110000: op = rr(ALU_GTYPE_SFT, ALU_STYPE_SRA);
            17'b00000000000111000: op = rr(ALU_GTYPE_MUL, ALU_STYPE_MULL);
            17'b00000000000111001: op = rr(ALU_GTYPE_MUL, ALU_STYPE_MULH);
            17'b00000000000111010: op = rr(ALU_GTYPE_MUL, ALU_STYPE_MULHU);
            17'b00000000001000000: op = rr(ALU_GTYPE_DIV, ALU_STYPE_DIV);
            17'b00000000001000001: op = rr(ALU_GTYPE_DIV, ALU_STYPE_MOD);
            17'b00000000001000010: op = rr(ALU_GTYPE_DIV, ALU_STYPE_DIVU);
            17'b00000000001000011: op = rr(ALU_GTYPE_DIV, ALU_STYPE_MODU);
            17'b00000000010000001: op = ri(IMM_U5, ALU_GTYPE_SFT, ALU_STYPE_SLL);
            17'b00000000010001001: op = ri(IMM_U5, ALU_GTYPE_SFT, ALU_STYPE_SRL);
            17'b00000000010010001: op = ri(IMM_U5, ALU_GTYPE_SFT, ALU_STYPE_SRA);
            17'b0000001000???????: op = ri(IMM_S12, ALU_GTYPE_INT, ALU_STYPE_SLT);
            17'b0000001001???????: op = ri(IMM_S12, ALU_GTYPE_INT, ALU_STYPE_SLTU);
            17'b0000001010???????: op = ri(IMM_S12, ALU_GTYPE_INT, ALU_STYPE_ADD);
            17'b0000001101???????: op = ri(IMM_U12, ALU_GTYPE_BW, ALU_STYPE_AND);
            17'b0000001110???????: op = ri(IMM_U12, ALU_GTYPE_BW, ALU_STYPE_OR);
            17'b0000001111???????: op = ri(IMM_U12, ALU_GTYPE_BW, ALU_STYPE_XOR);
            17'b0001010??????????: op = ri20(ALU_STYPE_LUI);      // lu12i
            17'b0001110??????????: op = ri20(ALU_STYPE_PCADDUI);  // pcaddu12i
            default:               op = NO_OP;
        endcase
    end

    always_comb begin
        hit_o                = op.hit;
        exec_o.inst          = inst_i;
        exec_o.unit          = (op.gtype inside {ALU_GTYPE_MUL, ALU_GTYPE_DIV}) ? UNIT_MDU
                                                                                : UNIT_ALU;
        exec_o.reg_r0        = op.r0;
        exec_o.reg_r1        = op.r1;
        exec_o.reg_w         = op.hit ? REG_W_RD : REG_W_NONE;  // every kept op writes rd
        exec_o.imm_type      = op.imm;
        exec_o.addr_imm_type = ADDR_IMM_S26;
        exec_o.alu_gtype     = op.gtype;
        exec_o.alu_stype     = op.stype;
        exec_o.target_type   = TARGET_REL;
        exec_o.cmp_type      = CMP_NONE;
        exec_o.jump          = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/la32_flow_mem_decoder.sv
`default_nettype none
`timescale 1ns/1ns

`include "la32_decode_config.svh"

module la32_flow_mem_decoder (
    input  logic [`LA32_INST_W-1:0] inst_i,
    output logic                    hit_o,
    output la32_uop_pkg::exec_ctrl_t exec_o,
    output la32_uop_pkg::mem_ctrl_t  mem_o
);

    import la32_isa_pkg::*;
    import la32_uop_pkg::*;

    logic [`LA32_INST_W-1:`LA32_OP6_LSB]  op6;
    logic [`LA32_INST_W-1:`LA32_OP10_LSB] op10;
    cmp_e                                 br_cmp;
    logic                                 is_jirl;
    logic                                 is_b;
    logic                                 is_bl;
    logic                                 is_br;
    logic                                 is_ls;

    assign op6  = inst_i[`LA32_INST_W-1:`LA32_OP6_LSB];
    assign op10 = inst_i[`LA32_INST_W-1:`LA32_OP10_LSB];

    always_comb begin
        unique case (op6)
            6'b010110: br_cmp = CMP_EQ;   // beq
            6'b010111: br_cmp = CMP_NE;
            6'b011000: br_cmp = CMP_LT;
            6'b011001: br_cmp = CMP_GE;
            6'b011010: br_cmp = CMP_LTU;
            6'b011011: br_cmp = CMP_GEU;
            default:   br_cmp = CMP_NONE;
        endcase
    end

    // size and direction of the load/store forms, all zero for anything else
    always_comb begin
        unique case (op10)
            10'b0010100000: mem_o = '{MEM_TYPE_BYTE, 1'b1, 1'b0};
            10'b0010100001: mem_o = '{MEM_TYPE_HALF, 1'b1, 1'b0};
            10'b0010100010: mem_o = '{MEM_TYPE_WORD, 1'b1, 1'b0};
            10'b0010100100: mem_o = '{MEM_TYPE_BYTE, 1'b0, 1'b1};
            10'b0010100101: mem_o = '{MEM_TYPE_HALF, 1'b0, 1'b1};
            10'b0010100110: mem_o = '{MEM_TYPE_WORD, 1'b0, 1'b1};
            10'b0010101000: mem_o = '{MEM_TYPE_UBYTE, 1'b1, 1'b0};
            10'b0010101001: mem_o = '{MEM_TYPE_UHALF, 1'b1, 1'b0};
            default:        mem_o = '{MEM_TYPE_BYTE, 1'b0, 1'b0};
        endcase
    end

    assign is_jirl = (op6 == 6'b010011);
    assign is_b    = (op6 == 6'b010100);
    assign is_bl   = (op6 == 6'b010101);
    assign is_br   = (br_cmp != CMP_NONE);
    assign is_ls   = mem_o.mem_read | mem_o.mem_write;
    assign hit_o   = is_jirl | is_b | is_bl | is_br | is_ls;

    always_comb begin
        exec_o.inst   = inst_i;
        exec_o.unit   = is_ls ? UNIT_LSU : UNIT_ALU;
        exec_o.reg_r0 = (is_br || mem_o.mem_write) ? REG_R0_RD : REG_R0_NONE;  // store data in rd
        exec_o.reg_r1 = (is_jirl || is_br || is_ls) ? REG_R1_RJ : REG_R1_NONE;
        exec_o.reg_w  = (is_jirl || mem_o.mem_read) ? REG_W_RD
                      : is_bl ? REG_W_R1 : REG_W_NONE;
        exec_o.imm_type      = IMM_U5;
        exec_o.addr_imm_type = is_ls ? ADDR_IMM_S12
                             : (is_jirl || is_br) ? ADDR_IMM_S16 : ADDR_IMM_S26;
        // the link forms compute pc + 4 in the ALU
        exec_o.alu_gtype   = (is_jirl || is_bl) ? ALU_GTYPE_LI : ALU_GTYPE_BW;
        exec_o.alu_stype   = (is_jirl || is_bl) ? ALU_STYPE_PCPLUS4 : ALU_STYPE_AND;
        exec_o.target_type = is_jirl ? TARGET_ABS : TARGET_REL;
        exec_o.cmp_type    = br_cmp;
        exec_o.jump        = is_jirl | is_b | is_bl | is_br;
    end

endmodule

`default_nettype wire

//--- hdl/la32_decode_reg.sv
`default_nettype none
`timescale 1ns/1ns

module la32_decode_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     valid_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            payload_o <= '0;
        end else if (!stall_i) begin
            valid_o   <= valid_i;
            payload_o <= payload_i;  // downstream looks at it only when valid
        end
    end

endmodule

`default_nettype wire

//--- hdl/la32_decode_stage.sv
`default_nettype none
`timescale 1ns/1ns

`include "la32_decode_config.svh"

module la32_decode_stage (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     inst_valid_i,
    input  logic                     stall_i,
    input  logic [`LA32_INST_W-1:0]  inst_i,
    output logic                     valid_o,
    output logic                     decode_err_o,
    output la32_uop_pkg::exec_ctrl_t exec_o,
    output la32_uop_pkg::mem_ctrl_t  mem_o
);

    import la32_isa_pkg::*;
    import la32_uop_pkg::*;

    logic       int_hit;
    logic       fm_hit;
    exec_ctrl_t int_exec;
    exec_ctrl_t fm_exec;
    mem_ctrl_t  fm_mem;
    exec_ctrl_t exec_d;
    logic       decode_err_d;

    la32_int_decoder i_int_dec (
        .inst_i (inst_i),
        .hit_o  (int_hit),
        .exec_o (int_exec)
    );

    la32_flow_mem_decoder i_fm_dec (
        .inst_i (inst_i),
        .hit_o  (fm_hit),
        .exec_o (fm_exec),
        .mem_o  (fm_mem)
    );

    // the two decoders never hit on the same word
    always_comb begin
        if (int_hit) begin
            exec_d = int_exec;
        end else if (fm_hit) begin
            exec_d = fm_exec;
        end else begin
            exec_d = '{
                inst:          inst_i,
                unit:          UNIT_ALU,
                reg_r0:        REG_R0_NONE,
                reg_r1:        REG_R1_NONE,
                reg_w:         REG_W_NONE,
                imm_type:      IMM_U5,
                addr_imm_type: ADDR_IMM_S26,
                alu_gtype:     ALU_GTYPE_BW,
                alu_stype:     ALU_STYPE_AND,
                target_type:   TARGET_REL,
                cmp_type:      CMP_NONE,
                jump:          1'b0
            };
        end
    end

    assign decode_err_d = inst_valid_i & ~(int_hit | fm_hit);

    la32_decode_reg #(.payload_t(exec_ctrl_t)) i_exec_reg (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .valid_i   (inst_valid_i),
        .payload_i (exec_d),
        .valid_o   (valid_o),
        .payload_o (exec_o)
    );

    // the error flag rides in the valid bit of the memory bundle register
    la32_decode_reg #(.payload_t(mem_ctrl_t)) i_mem_reg (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .valid_i   (decode_err_d),
        .payload_i (fm_mem),
        .valid_o   (decode_err_o),
        .payload_o (mem_o)
    );

endmodule

`default_nettype wire

//--- bench/la32_decode_props.sv
`default_nettype none
`timescale 1ns/1ns

module la32_decode_props (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     stall_i,
    input logic                     valid_i,
    input logic                     decode_err_i,
    input la32_uop_pkg::exec_ctrl_t exec_i,
    input la32_uop_pkg::mem_ctrl_t  mem_i
);

    err_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        decode_err_i |-> valid_i)
        else $error("decode error flagged on a cycle without valid");

    // a stall at one edge leaves the registered result unchanged after it
    hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable({valid_i, decode_err_i, exec_i, mem_i}))
        else $error("stage outputs changed while stalled");

    not_load_and_store: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_i.mem_read && mem_i.mem_write))
        else $error("memory bundle flags a load and a store at once");

endmodule

bind la32_decode_stage la32_decode_props i_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .valid_i      (valid_o),
    .decode_err_i (decode_err_o),
    .exec_i       (exec_o),
    .mem_i        (mem_o)
);

`default_nettype wire

//--- bench/la32_decode_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "la32_decode_config.svh"

module la32_decode_tb;

    import la32_isa_pkg::*;
    import la32_uop_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int KEPT_CYCLES  = 600;
    localparam int UNDEF_CYCLES = 120;
    localparam int STALL_CYCLES = 80;
    localparam int TOTAL_CYCLES = RESET_CYCLES + KEPT_CYCLES + UNDEF_CYCLES + STALL_CYCLES;
    localparam int N_KEPT       = 46;
    localparam int N_OPS        = 60;

    // UND marks dropped encodings that have to raise the decode error
    typedef enum logic [3:0] {RR, RI5, RIS12, RIU12, LI, JIRL, BJ, BL, BR, LD, ST, UND} cls_e;

    typedef struct packed {
        logic [`LA32_INST_W-1:0] base;  // opcode bits, the rest is random
        int                      opw;   // fixed bits counted down from bit 31
        cls_e                    cls;
        int                      grp;   // group 0 bw, 1 li, 2 int, 3 sft, 4 mul, 5 div
        int                      sub;   // ALU subtype, compare kind or memory type
    } op_entry_t;

    // the 46 kept encodings come first, then the dropped ones
    localparam op_entry_t OPS [N_OPS] = '{
        '{'h00100000, 17, RR, 2, 0}, '{'h00110000, 17, RR, 2, 1}, '{'h00120000, 17, RR, 2, 2},
        '{'h00128000, 17, RR, 2, 3}, '{'h00140000, 17, RR, 0, 3}, '{'h00148000, 17, RR, 0, 0},
        '{'h00150000, 17, RR, 0, 1}, '{'h00158000, 17, RR, 0, 2}, '{'h00170000, 17, RR, 3, 0},
        '{'h00178000, 17, RR, 3, 1}, '{'h00180000, 17, RR, 3, 2}, '{'h001c0000, 17, RR, 4, 0},
        '{'h001c8000, 17, RR, 4, 1}, '{'h001d0000, 17, RR, 4, 2}, '{'h00200000, 17, RR, 5, 0},
        '{'h00208000, 17, RR, 5, 1}, '{'h00210000, 17, RR, 5, 2}, '{'h00218000, 17, RR, 5, 3},
        '{'h00408000, 17, RI5, 3, 0}, '{'h00448000, 17, RI5, 3, 1},
        '{'h00488000, 17, RI5, 3, 2}, '{'h02000000, 10, RIS12, 2, 2},
        '{'h02400000, 10, RIS12, 2, 3}, '{'h02800000, 10, RIS12, 2, 0},
        '{'h03400000, 10, RIU12, 0, 0}, '{'h03800000, 10, RIU12, 0, 1},
        '{'h03c00000, 10, RIU12, 0, 2}, '{'h14000000, 7, LI, 1, 0}, '{'h1c000000, 7, LI, 1, 1},
        '{'h4c000000, 6, JIRL, 0, 0}, '{'h50000000, 6, BJ, 0, 0}, '{'h54000000, 6, BL, 0, 0},
        '{'h58000000, 6, BR, 0, 1}, '{'h5c000000, 6, BR, 0, 2}, '{'h60000000, 6, BR, 0, 3},
        '{'h64000000, 6, BR, 0, 4}, '{'h68000000, 6, BR, 0, 5}, '{'h6c000000, 6, BR, 0, 6},
        '{'h28000000, 10, LD, 0, 0}, '{'h28400000, 10, LD, 0, 1}, '{'h28800000, 10, LD, 0, 2},
        '{'h29000000, 10, ST, 0, 0}, '{'h29400000, 10, ST, 0, 1}, '{'h29800000, 10, ST, 0, 2},
        '{'h2a000000, 10, LD, 0, 3}, '{'h2a400000, 10, LD, 0, 4},
        '{'h002b0000, 17, UND, 0, 0}, '{'h002a0000, 17, UND, 0, 0},
        '{'h06483800, 32, UND, 0, 0}, '{'h06488000, 17, UND, 0, 0},
        '{'h06482800, 32, UND, 0, 0}, '{'h06498000, 17, UND, 0, 0},
        '{'h04000000, 8, UND, 0, 0}, '{'h00006000, 22, UND, 0, 0},
        '{'h20000000, 8, UND, 0, 0}, '{'h21000000, 8, UND, 0, 0},
        '{'h38720000, 17, UND, 0, 0}, '{'h38728000, 17, UND, 0, 0},
        '{'h2ac00000, 10, UND, 0, 0}, '{'h06000000, 10, UND, 0, 0}
    };

    logic                    clk_i;
    logic                    rst_i;
    logic                    inst_valid_i;
    logic                    stall_i;
    logic [`LA32_INST_W-1:0] inst_i;
    logic                    valid_o;
    logic                    decode_err_o;
    exec_ctrl_t              exec_o;
    mem_ctrl_t               mem_o;

    logic [31:0] lcg_state = 32'hb1b3;
    int          n_checked = 0;
    string       test_name = "reset";

    la32_decode_stage i_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall_i),
        .inst_i       (inst_i),
        .valid_o      (valid_o),
        .decode_err_o (decode_err_o),
        .exec_o       (exec_o),
        .mem_o        (mem_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void ref_decode(input logic [`LA32_INST_W-1:0] w, output exec_ctrl_t e,
                                       output mem_ctrl_t m, output logic hit);
        op_entry_t t;
        int        i;
        e = '0;  // zero codes are alu, no sources, u5, bw, relative, no compare
        e.inst = w;
        e.addr_imm_type = ADDR_IMM_S26;
        m = '0;
        hit = 1'b0;
        t = OPS[0];
        for (i = 0; i < N_KEPT; i++) begin
            if ((w & ~(32'hffff_ffff >> OPS[i].opw)) == OPS[i].base) begin
                hit = 1'b1;
                t = OPS[i];
            end
        end
        if (hit) begin
            case (t.cls)
                RR, RI5, RIS12, RIU12: begin
                    e.unit = (t.grp >= 4) ? UNIT_MDU : UNIT_ALU;  // mul and div groups
                    e.reg_r0 = (t.cls == RR) ? REG_R0_RK : REG_R0_IMM;
                    e.reg_r1 = REG_R1_RJ;
                    e.reg_w = REG_W_RD;
                    e.imm_type = (t.cls == RIS12) ? IMM_S12 : (t.cls == RIU12) ? IMM_U12 : IMM_U5;
                    e.alu_gtype = alu_gtype_e'(t.grp);
                    e.alu_stype = alu_stype_e'(t.sub);
                end
                LI: begin
                    e.reg_r0 = REG_R0_IMM;
                    e.reg_w = REG_W_RD;
                    e.imm_type = IMM_S20;
                    e.alu_gtype = ALU_GTYPE_LI;
                    e.alu_stype = alu_stype_e'(t.sub);
                end
                JIRL, BJ, BL, BR: begin
                    e.jump = 1'b1;
                    e.cmp_type = cmp_e'(t.sub);
                    e.target_type = (t.cls == JIRL) ? TARGET_ABS : TARGET_REL;
                    e.addr_imm_type = (t.cls inside {JIRL, BR}) ? ADDR_IMM_S16 : ADDR_IMM_S26;
                    e.reg_r0 = (t.cls == BR) ? REG_R0_RD : REG_R0_NONE;
                    e.reg_r1 = (t.cls inside {JIRL, BR}) ? REG_R1_RJ : REG_R1_NONE;
                    e.reg_w = (t.cls == JIRL) ? REG_W_RD : (t.cls == BL) ? REG_W_R1 : REG_W_NONE;
                    if (t.cls inside {JIRL, BL}) begin  // the link value is pc + 4
                        e.alu_gtype = ALU_GTYPE_LI;
                        e.alu_stype = ALU_STYPE_PCPLUS4;
                    end
                end
                default: begin
                    e.unit = UNIT_LSU;
                    e.reg_r0 = (t.cls == ST) ? REG_R0_RD : REG_R0_NONE;  // store data
                    e.reg_r1 = REG_R1_RJ;
                    e.reg_w = (t.cls == LD) ? REG_W_RD : REG_W_NONE;
                    e.addr_imm_type = ADDR_IMM_S12;
                    m.mem_type = mem_type_e'(t.sub);
                    m.mem_read = (t.cls == LD);
                    m.mem_write = (t.cls == ST);
                end
            endcase
        end
    endfunction

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    // one word from table rows lo to hi - 1, with random don't-care bits
    task automatic drive_word(input int lo, input int hi, input logic stall);
        logic [31:0] r;
        op_entry_t   t;
        @(posedge clk_i);
        #5;
        r = lcg_next();
        t = OPS[lo + int'(r[23:8]) % (hi - lo)];
        inst_i = (lcg_next() & ~(32'hffff_ffff >> t.opw)) | t.base;
        inst_valid_i = (r[2:0] != 3'd0);
        stall_i = stall;
    endtask

    initial begin : stimulus
        int i;
        clk_i = 1'b0;
        rst_i = 1'b1;
        inst_valid_i = 1'b0;
        stall_i = 1'b0;
        inst_i = '0;
        repeat (RESET_CYCLES) drive_word(0, N_OPS, 1'b0);
        rst_i = 1'b0;
        test_name = "kept";
        repeat (KEPT_CYCLES) drive_word(0, N_KEPT, 1'b0);
        test_name = "undefined";
        repeat (UNDEF_CYCLES) drive_word(N_KEPT, N_OPS, 1'b0);
        test_name = "stall";
        for (i = 0; i < STALL_CYCLES; i++) begin
            drive_word(0, N_OPS, (i % 8) >= 4);  // four cycles held in every eight
        end
        @(posedge clk_i);
        #5;
        stall_i = 1'b0;
        inst_valid_i = 1'b0;
        repeat (2) @(negedge clk_i);
        if (n_checked >= TOTAL_CYCLES) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("only %0d output compares ran, too few for the stimulus", n_checked);
            stop_with_failure();
        end
    end

    // the model follows the stage register, outputs are compared mid-cycle
    initial begin : compare
        exec_ctrl_t exp_exec;
        mem_ctrl_t  exp_mem;
        logic       exp_valid;
        logic       exp_err;
        logic       hit;
        forever begin
            @(posedge clk_i);
            if (rst_i) begin
                exp_exec = '0;
                exp_mem = '0;
                exp_valid = 1'b0;
                exp_err = 1'b0;
            end else if (!stall_i) begin
                ref_decode(inst_i, exp_exec, exp_mem, hit);
                exp_valid = inst_valid_i;
                exp_err = inst_valid_i & ~hit;
            end
            @(negedge clk_i);
            check("valid", 64'(exp_valid), 64'(valid_o));
            check("decode_err", 64'(exp_err), 64'(decode_err_o));
            check("exec", 64'(exp_exec), 64'(exec_o));
            check("mem", 64'(exp_mem), 64'(mem_o));
            n_checked++;
        end
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + 20) * 100);
        $display("watchdog expired before the stimulus finished");
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/la32_isa_pkg.sv
hdl/la32_uop_pkg.sv
hdl/la32_int_decoder.sv
hdl/la32_flow_mem_decoder.sv
hdl/la32_decode_reg.sv
hdl/la32_decode_stage.sv
bench/la32_decode_props.sv
bench/la32_decode_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = la32_decode_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
